// ==== testbench/queue_patterns.txt ====
// op (1 request, 2 serve), current floor, origin, destination
// then expected dropped, count, stops 0 to 7, all hex
1 0 3 7 0 2 3 7 0 0 0 0 0 0
1 1 2 5 0 4 2 3 5 7 0 0 0 0
2 1 0 0 0 3 3 5 7 0 0 0 0 0
1 2 5 9 0 4 3 5 7 9 0 0 0 0
1 2 4 4 0 5 3 4 5 7 9 0 0 0
1 2 8 6 0 7 3 4 5 7 8 9 6 0
1 2 1 0 1 7 3 4 5 7 8 9 6 0
2 2 0 0 0 6 4 5 7 8 9 6 0 0
1 3 a 2 0 8 4 5 7 8 9 6 a 2
1 3 1 2 1 8 4 5 7 8 9 6 a 2
2 3 0 0 0 7 5 7 8 9 6 a 2 0
2 3 0 0 0 6 7 8 9 6 a 2 0 0
2 3 0 0 0 5 8 9 6 a 2 0 0 0
2 3 0 0 0 4 9 6 a 2 0 0 0 0
1 c b 8 0 6 b 9 8 6 a 2 0 0
2 c 0 0 0 5 9 8 6 a 2 0 0 0
2 c 0 0 0 4 8 6 a 2 0 0 0 0
2 c 0 0 0 3 6 a 2 0 0 0 0 0
2 c 0 0 0 2 a 2 0 0 0 0 0 0
2 c 0 0 0 1 2 0 0 0 0 0 0 0
2 c 0 0 0 0 0 0 0 0 0 0 0 0
2 c 0 0 0 0 0 0 0 0 0 0 0 0
1 5 5 5 0 1 5 0 0 0 0 0 0 0
1 5 3 5 0 3 5 3 5 0 0 0 0 0
1 5 4 5 0 4 5 4 3 5 0 0 0 0
2 5 0 0 0 3 4 3 5 0 0 0 0 0

// ==== src.f ====
src/elevator_pkg.sv
src/request_control.sv
src/request_datapath.sv
src/stop_queue.sv
src/elevator_queue_top.sv
testbench/elevator_queue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -j 0 --top-module elevator_queue_tb -f src.f \
    && ./obj_dir/Velevator_queue_tb | tee /dev/stderr | grep -qxF "All tests passed!" \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }

// ==== testbench/elevator_queue_tb.sv ====
`timescale 1ns/1ps

module elevator_queue_tb;

    import elevator_pkg::*;

    localparam int         DEPTH      = 8;
    localparam int         FIELDS     = 14;   // op, floor, origin, destination, dropped, count, 8 stops
    localparam int         MAX_LINES  = 32;
    localparam int         BUSY_LIMIT = 50;
    localparam logic [7:0] OP_NONE    = 8'h00;
    localparam logic [7:0] OP_REQUEST = 8'h01;

    logic     clock;
    logic     reset;
    logic     new_request;
    request_t request;
    logic     serve;
    floor_t   current_floor;
    count_t   peek_addr;
    logic     busy;
    count_t   stop_count;
    floor_t   head_floor;
    floor_t   peek_floor;
    logic     dropped;

    logic [7:0] pattern_mem [FIELDS*MAX_LINES];
    int         line_count;
    int         cycles;
    int         cycle_limit = 0;
    int         mismatches;
    int         failures;
    int         dropped_pulses;
    int         seed;

    elevator_queue_top #(
        .DEPTH (DEPTH)
    ) elevator_queue_top_i (
        .clock         (clock),
        .reset         (reset),
        .new_request   (new_request),
        .request       (request),
        .serve         (serve),
        .current_floor (current_floor),
        .peek_addr     (peek_addr),
        .busy          (busy),
        .stop_count    (stop_count),
        .head_floor    (head_floor),
        .peek_floor    (peek_floor),
        .dropped       (dropped)
    );

    always #20 clock = ~clock;

    // dropped pulses counted mid-cycle
    always @(negedge clock) begin
        if (dropped)
            dropped_pulses = dropped_pulses + 1;
    end

    initial begin
        cycles = 0;
        @(posedge clock);
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles = cycles + 1;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("Test failures found");
        $finish;
    end

    task automatic check_floor(input string name, input floor_t expected, input floor_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic wait_idle(input string name);
        int waited;
        waited = 0;
        while (busy) begin
            if (waited >= BUSY_LIMIT) begin
                $display("%s: busy stayed high for %0d cycles", name, waited);
                failures++;
                return;
            end
            @(posedge clock);
            #2;
            waited++;
        end
    endtask

    task automatic sweep_queue(input string name, input int base);
        for (int a = 0; a < DEPTH; a++) begin
            peek_addr = count_t'(a);
            @(negedge clock);
            check_floor($sformatf("%s stop %0d", name, a), pattern_mem[base + 6 + a][3:0],
                        peek_floor);
            @(posedge clock);
            #2;
        end
    endtask

    task automatic run_line(input int line);
        int    base;
        int    gap;
        int    pulses_before;
        string name;
        base = line * FIELDS;
        name = $sformatf("line %0d", line + 1);
        gap  = $unsigned($random(seed)) % 4;   // idle cycles before the operation
        repeat (gap) @(posedge clock);
        @(posedge clock);
        #2;
        current_floor = pattern_mem[base + 1][3:0];
        pulses_before = dropped_pulses;
        if (pattern_mem[base] == OP_REQUEST) begin
            request.origin      = pattern_mem[base + 2][3:0];
            request.destination = pattern_mem[base + 3][3:0];
            new_request         = 1'b1;
            @(posedge clock);
            #2;
            new_request = 1'b0;
            check_flag({name, " busy"}, 1'b1, busy);   // busy rises the cycle after the call
            wait_idle(name);
        end else begin
            serve = 1'b1;
            @(posedge clock);
            #2;
            serve = 1'b0;
        end
        @(negedge clock);
        check_flag({name, " dropped"}, pattern_mem[base + 4][0], dropped_pulses != pulses_before);
        check_count({name, " count"}, pattern_mem[base + 5][3:0], stop_count);
        check_floor({name, " head"}, pattern_mem[base + 6][3:0], head_floor);
        @(posedge clock);
        #2;
        sweep_queue(name, base);
    endtask

    initial begin
        seed           = 32'hf1a200d3;
        clock          = 1'b0;
        reset          = 1'b1;
        new_request    = 1'b0;
        request        = '0;
        serve          = 1'b0;
        current_floor  = '0;
        peek_addr      = '0;
        mismatches     = 0;
        failures       = 0;
        dropped_pulses = 0;
        for (int k = 0; k < FIELDS * MAX_LINES; k++)
            pattern_mem[k] = OP_NONE;
        $readmemh("testbench/queue_patterns.txt", pattern_mem);
        line_count = 0;
        while (line_count < MAX_LINES && pattern_mem[line_count * FIELDS] != OP_NONE)
            line_count++;
        cycle_limit = 60 * (line_count + 1) + 8;   // spare line for the reset checks
        if (line_count == 0) begin
            $display("no operations could be read from the pattern file");
            failures++;
        end
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        check_count("after reset count", 4'd0, stop_count);
        check_flag("after reset busy", 1'b0, busy);
        check_flag("after reset dropped", 1'b0, dropped);
        for (int line = 0; line < line_count; line++)
            run_line(line);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== src/elevator_queue_top.sv ====
`timescale 1ns/1ps

module elevator_queue_top #(
    parameter int DEPTH = 8
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   new_request,
    input  elevator_pkg::request_t request,
    input  logic                   serve,
    input  elevator_pkg::floor_t   current_floor,
    input  elevator_pkg::count_t   peek_addr,
    output logic                   busy,
    output elevator_pkg::count_t   stop_count,
    output elevator_pkg::floor_t   head_floor,
    output elevator_pkg::floor_t   peek_floor,
    output logic                   dropped
);

    import elevator_pkg::*;

    step_t       steps;
    scan_flags_t flags;
    count_t      scan_addr;
    count_t      count;
    floor_t      write_floor;
    floor_t      entry;
    floor_t      previous_entry;
    logic        serve_idle;

    assign serve_idle = serve && !busy;   // serve ignored mid-scan
    assign stop_count = count;

    request_control request_control_i (
        .clock       (clock),
        .reset       (reset),
        .new_request (new_request),
        .flags       (flags),
        .steps       (steps),
        .busy        (busy),
        .dropped     (dropped)
    );

    request_datapath #(
        .DEPTH (DEPTH)
    ) request_datapath_i (
        .clock          (clock),
        .reset          (reset),
        .request        (request),
        .current_floor  (current_floor),
        .steps          (steps),
        .entry          (entry),
        .previous_entry (previous_entry),
        .count          (count),
        .scan_addr      (scan_addr),
        .write_floor    (write_floor),
        .flags          (flags)
    );

    stop_queue #(
        .DEPTH (DEPTH)
    ) stop_queue_i (
        .clock          (clock),
        .reset          (reset),
        .steps          (steps),
        .scan_addr      (scan_addr),
        .peek_addr      (peek_addr),
        .write_floor    (write_floor),
        .serve          (serve_idle),
        .entry          (entry),
        .previous_entry (previous_entry),
        .head_floor     (head_floor),
        .peek_floor     (peek_floor),
        .count          (count)
    );

endmodule

// ==== src/stop_queue.sv ====
`timescale 1ns/1ps

module stop_queue #(
    parameter int DEPTH = 8
) (
    input  logic                 clock,
    input  logic                 reset,
    input  elevator_pkg::step_t  steps,
    input  elevator_pkg::count_t scan_addr,
    input  elevator_pkg::count_t peek_addr,
    input  elevator_pkg::floor_t write_floor,
    input  logic                 serve,
    output elevator_pkg::floor_t entry,
    output elevator_pkg::floor_t previous_entry,
    output elevator_pkg::floor_t head_floor,
    output elevator_pkg::floor_t peek_floor,
    output elevator_pkg::count_t count
);

    import elevator_pkg::*;

    floor_t stops      [DEPTH];
    floor_t next_stops [DEPTH];
    count_t count_q;
    logic   pop;

    // unused slots read as zero
    function automatic floor_t read_stop(input count_t addr);
        floor_t value;
        value = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if ((count_t'(i) == addr) && (addr < count_q))
                value = stops[i];
        end
        return value;
    endfunction

    assign pop = serve && (count_q != '0);

    always_comb begin
        next_stops = stops;
        if (steps.insert) begin
            for (int i = 1; i < DEPTH; i++) begin
                if (count_t'(i) > scan_addr)
                    next_stops[i] = stops[i - 1];   // make room above the slot
            end
            for (int i = 0; i < DEPTH; i++) begin
                if (count_t'(i) == scan_addr)
                    next_stops[i] = write_floor;
            end
        end else if (steps.append) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (count_t'(i) == count_q)
                    next_stops[i] = write_floor;
            end
        end else if (pop) begin
            for (int i = 0; i < DEPTH - 1; i++)
                next_stops[i] = stops[i + 1];   // head leaves, rest moves down
        end
    end

    always_ff @(posedge clock) begin
        stops <= next_stops;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            count_q <= '0;
        else if (steps.insert || steps.append)
            count_q <= count_q + count_t'(1);
        else if (pop)
            count_q <= count_q - count_t'(1);
    end

    always_comb begin
        entry          = read_stop(scan_addr);
        previous_entry = read_stop(scan_addr - count_t'(1));
        head_floor     = read_stop('0);
        peek_floor     = read_stop(peek_addr);
    end

    assign count = count_q;

    // relies on the refusal check in the control unit
    count_bound_a: assert property (@(posedge clock) disable iff (reset)
        count_q <= count_t'(DEPTH))
        else $error("stop count %0d above depth", count_q);

    empty_serve_a: assert property (@(posedge clock) disable iff (reset)
        (serve && (count_q == '0) && !steps.insert && !steps.append) |=> (count_q == '0))
        else $error("serve on an empty queue changed the count");

endmodule

// ==== src/request_datapath.sv ====
`timescale 1ns/1ps

module request_datapath #(
    parameter int DEPTH = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    input  elevator_pkg::request_t    request,
    input  elevator_pkg::floor_t      current_floor,
    input  elevator_pkg::step_t       steps,
    input  elevator_pkg::floor_t      entry,
    input  elevator_pkg::floor_t      previous_entry,
    input  elevator_pkg::count_t      count,
    output elevator_pkg::count_t      scan_addr,
    output elevator_pkg::floor_t      write_floor,
    output elevator_pkg::scan_flags_t flags
);

    import elevator_pkg::*;

    request_t request_q;
    count_t   scan_q;
    count_t   position_q;
    floor_t   scan_floor;
    floor_t   previous_floor;
    logic     above_previous;
    logic     below_previous;
    logic     same_ends;

    // call registers loaded once per pass
    always_ff @(posedge clock) begin
        if (steps.load_request)
            request_q <= request;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            scan_q <= '0;
        else if (steps.clear_scan)
            scan_q <= '0;
        else if (steps.load_scan_from_position)
            scan_q <= position_q;
        else if (steps.step_scan)
            scan_q <= scan_q + count_t'(1);
    end

    // where the origin landed, or the slot that already held it
    always_ff @(posedge clock) begin
        if (steps.save_position || (steps.discard && !steps.select_destination))
            position_q <= scan_q;
    end

    assign scan_floor     = steps.select_destination ? request_q.destination
                                                     : request_q.origin;
    assign previous_floor = (scan_q == '0) ? current_floor : previous_entry;

    // ride-along test in either travel direction
    assign above_previous = (previous_floor < scan_floor) && (scan_floor < entry);
    assign below_previous = (previous_floor > scan_floor) && (scan_floor > entry);
    assign same_ends      = steps.select_destination
                            && (request_q.destination == request_q.origin);

    assign flags.in_range = (scan_q < count);
    assign flags.fit      = flags.in_range && (above_previous || below_previous);
    assign flags.repeated = (flags.in_range && (entry == scan_floor)) || same_ends;
    assign flags.full     = (count > count_t'(DEPTH - 2));   // room for both floors

    assign scan_addr   = scan_q;
    assign write_floor = scan_floor;

    // scan stops at count, and serve only runs while the scan is parked at 0
    scan_in_bounds_a: assert property (@(posedge clock) disable iff (reset)
        scan_q <= count)
        else $error("scan address %0d beyond count %0d", scan_q, count);

endmodule

// ==== src/request_control.sv ====
`timescale 1ns/1ps

module request_control (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      new_request,
    input  elevator_pkg::scan_flags_t flags,
    output elevator_pkg::step_t       steps,
    output logic                      busy,
    output logic                      dropped
);

    typedef enum logic [3:0] {
        wait_call           = 4'h0,
        load_call           = 4'h1,
        check_first_origin  = 4'h2,
        check_origin        = 4'h3,
        next_origin         = 4'h4,
        fit_origin          = 4'h5,
        append_origin       = 4'h6,
        append_destination  = 4'h7,
        prepare_destination = 4'h8,
        skip                = 4'h9,
        next_destination    = 4'ha,
        check_destination   = 4'hb,
        fit_destination     = 4'hc,
        discard_origin      = 4'hd,
        discard_destination = 4'he
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            state <= wait_call;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            wait_call:
                next_state = new_request ? load_call : wait_call;
            load_call:
                next_state = flags.full ? wait_call : check_first_origin;   // refused call
            check_first_origin:
                next_state = flags.in_range ? check_origin : append_origin;  // empty queue
            check_origin: begin
                if (flags.repeated)
                    next_state = discard_origin;
                else if (!flags.in_range)
                    next_state = append_origin;   // ran off the end
                else if (flags.fit)
                    next_state = fit_origin;
                else
                    next_state = next_origin;
            end
            next_origin:
                next_state = check_origin;
            fit_origin,
            append_origin,
            discard_origin:
                next_state = prepare_destination;
            prepare_destination:
                next_state = skip;   // scan restarts one past the origin
            skip:
                next_state = check_destination;
            check_destination: begin
                if (flags.repeated)
                    next_state = discard_destination;
                else if (!flags.in_range)
                    next_state = append_destination;
                else if (flags.fit)
                    next_state = fit_destination;
                else
                    next_state = next_destination;
            end
            next_destination:
                next_state = check_destination;
            fit_destination,
            append_destination,
            discard_destination:
                next_state = wait_call;
            default:
                next_state = wait_call;
        endcase
    end

    // Moore decode of the datapath and queue strobes
    always_comb begin
        steps = '0;
        case (state)
            wait_call: begin
                steps.clear_scan = 1'b1;   // scan parked at 0 while idle
            end
            load_call: begin
                steps.load_request = 1'b1;
                steps.clear_scan   = 1'b1;
            end
            next_origin: begin
                steps.step_scan = 1'b1;
            end
            fit_origin: begin
                steps.insert        = 1'b1;
                steps.save_position = 1'b1;
            end
            append_origin: begin
                steps.append        = 1'b1;
                steps.save_position = 1'b1;
            end
            discard_origin: begin
                steps.discard = 1'b1;   // datapath keeps the matched slot
            end
            prepare_destination: begin
                steps.load_scan_from_position = 1'b1;
                steps.select_destination      = 1'b1;
            end
            skip,
            next_destination: begin
                steps.step_scan          = 1'b1;
                steps.select_destination = 1'b1;
            end
            check_destination: begin
                steps.select_destination = 1'b1;
            end
            fit_destination: begin
                steps.insert             = 1'b1;
                steps.select_destination = 1'b1;
            end
            append_destination: begin
                steps.append             = 1'b1;
                steps.select_destination = 1'b1;
            end
            discard_destination: begin
                steps.discard            = 1'b1;
                steps.select_destination = 1'b1;
            end
            default: begin
                steps = '0;
            end
        endcase
    end

    assign busy    = (state != wait_call);
    assign dropped = (state == load_call) && flags.full;   // one-cycle refusal pulse

    // the queue takes one write per cycle
    insert_append_exclusive_a: assert property (@(posedge clock) disable iff (reset)
        !(steps.insert && steps.append))
        else $error("insert and append raised together");

    busy_after_reset_a: assert property (@(posedge clock)
        $past(reset) |-> !busy)
        else $error("busy high one cycle after reset");

    // request registers must capture the call that started this pass
    load_follows_request_a: assert property (@(posedge clock) disable iff (reset)
        steps.load_request |-> $past(new_request))
        else $error("load_request without a preceding new_request");

endmodule

// ==== src/elevator_pkg.sv ====
package elevator_pkg;

    localparam int FLOOR_BITS = 4;   // 16 floors
    localparam int COUNT_BITS = 4;   // queue depth up to 15

    typedef logic [FLOOR_BITS-1:0] floor_t;
    typedef logic [COUNT_BITS-1:0] count_t;

    // a call as it enters the top level
    typedef struct packed {
        floor_t origin;
        floor_t destination;
    } request_t;

    // comparator results for the entry under the scan address
    typedef struct packed {
        logic in_range;   // scan address below count
        logic fit;        // floor strictly between previous and entry
        logic repeated;   // floor already queued
        logic full;       // fewer than two free slots
    } scan_flags_t;

    // one control step decoded from the FSM state
    typedef struct packed {
        logic load_request;
        logic clear_scan;
        logic load_scan_from_position;
        logic step_scan;
        logic save_position;
        logic select_destination;
        logic insert;
        logic append;
        logic discard;
    } step_t;

endpackage
